/* tests/ser_wb_tests.txt */
# op cmd wdata expect, all hex; op R or W sets command bit 7
# cmd gives command bits 6:0, address in bits 3:0, bits 6:4 ignored by the bridge
R 00 00 00
R 01 00 00
R 02 00 00
R 03 00 00
R 04 00 00
R 05 00 00
R 06 00 00
R 07 00 00
R 08 00 00
R 09 00 00
R 0A 00 00
R 0B 00 00
R 0C 00 00
R 0D 00 00
R 0E 00 00
R 0F 00 00
W 03 A5 01
R 03 00 A5
R 73 00 A5
R 04 00 00
W 0C 3C 01
W 0C C3 01
R 0C 00 C3
R 5C 00 C3
W 20 FF 01
R 00 00 FF
R 0F 00 00
R 03 00 A5

/* filelist.f */
common/ser_wb_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/ser_wb_ctrl.sv
src/wb_regfile.sv
src/ser_wb_top.sv
tests/ser_wb_assert.sv
tests/tb_ser_wb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_ser_wb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# The simulator exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_ser_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ser_wb;

  localparam int BIT_CLKS     = ser_wb_pkg::CLKS_PER_BIT;
  // Two request frames plus a few cycles of bridge latency fit easily
  localparam int RESP_TIMEOUT = 30 * BIT_CLKS;
  localparam int RANDOM_PAIRS = 20;

  logic clk_i;
  logic rst_ni;
  logic rx_i;
  logic tx_o;

  // Register contents the DUT should hold
  logic [ser_wb_pkg::DATA_W-1:0] sb_regs [16];

  ser_wb_top u_dut (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rx_i   (rx_i),
    .tx_o   (tx_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic end_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // 8N1 frame on rx_i, each bit held for one bit time
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx_i = frame[i];
      repeat (BIT_CLKS) @(negedge clk_i);
    end
  endtask

  task automatic receive_byte(output logic [7:0] data);
    int waited;
    waited = 0;
    while (tx_o !== 1'b0) begin
      @(negedge clk_i);
      waited++;
      assert (waited < RESP_TIMEOUT) else begin
        $display("No start bit on tx_o within %0d clock cycles", RESP_TIMEOUT);
        end_with_failure();
      end
    end
    // Move to the middle of the start bit
    repeat (BIT_CLKS / 2 - 1) @(negedge clk_i);
    assert (tx_o === 1'b0) else begin
      $display("Start bit on tx_o went high again before its middle");
      end_with_failure();
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk_i);
      data[i] = tx_o;
    end
    repeat (BIT_CLKS) @(negedge clk_i);
    assert (tx_o === 1'b1) else begin
      $display("Stop bit of the response on tx_o was low");
      end_with_failure();
    end
  endtask

  // One command with its response; the response may start before the last stop bit ends
  task automatic run_command(input logic is_write, input logic [7:0] cmd_lo,
                             input logic [7:0] wdata, input logic [7:0] expected);
    logic [7:0] cmd;
    logic [7:0] got;
    cmd = cmd_lo;
    cmd[ser_wb_pkg::CMD_WRITE_BIT] = is_write;
    fork
      begin
        send_byte(cmd);
        if (is_write) begin
          send_byte(wdata);
        end
      end
      receive_byte(got);
    join
    assert (got === expected) else begin
      $display("[ERROR] %0t ns tx_byte expected 0x%02h received 0x%02h (command 0x%02h)",
               $time, expected, got, cmd);
      end_with_failure();
    end
    if (is_write) begin
      sb_regs[cmd[3:0]] = wdata;
    end
  endtask

  task automatic run_file_lines();
    int         fd;
    int         n;
    string      line;
    byte        op;
    logic [7:0] cmd_lo;
    logic [7:0] wdata;
    logic [7:0] expected;
    fd = $fopen("tests/ser_wb_tests.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the test file tests/ser_wb_tests.txt");
      end_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h", op, cmd_lo, wdata, expected);
      assert (n == 4 && (op == "R" || op == "W")) else begin
        $display("Test file line could not be parsed: %s", line);
        end_with_failure();
      end
      cmd_lo[ser_wb_pkg::CMD_WRITE_BIT] = 1'b0;
      run_command(op == "W", cmd_lo, wdata, expected);
    end
    $fclose(fd);
  endtask

  task automatic run_random_pairs();
    logic [31:0] rnd;
    logic [3:0]  wr_adr;
    logic [3:0]  rd_adr;
    logic [7:0]  wr_dat;
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      rnd    = $urandom;
      wr_adr = rnd[3:0];
      wr_dat = rnd[15:8];
      // Half the reads hit the address just written
      rd_adr = rnd[24] ? wr_adr : rnd[7:4];
      // Ignored command bits 6:4 take random values
      run_command(1'b1, {1'b0, rnd[18:16], wr_adr}, wr_dat, ser_wb_pkg::WR_ACK_BYTE);
      run_command(1'b0, {1'b0, rnd[21:19], rd_adr}, 8'h00, sb_regs[rd_adr]);
    end
  endtask

  initial begin
    int unsigned seed_ret;
    seed_ret = $urandom(35);
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    rx_i   = 1'b1;
    for (int i = 0; i < 16; i++) begin
      sb_regs[i] = '0;
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (tx_o === 1'b1) else begin
      $display("[ERROR] %0t ns tx_o expected 1 received %b", $time, tx_o);
      end_with_failure();
    end
    run_file_lines();
    run_random_pairs();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/ser_wb_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ser_wb_assert (
  input logic                          clk_i,
  input logic                          rst_ni,
  input ser_wb_pkg::ctrl_state_e       state_i,
  input logic                          wb_stb_i,
  input logic                          wb_we_i,
  input logic [ser_wb_pkg::ADR_W-1:0]  wb_adr_i,
  input logic [ser_wb_pkg::DATA_W-1:0] wb_dat_i,
  input logic                          wb_ack_i,
  input logic                          tx_busy_i,
  input logic                          tx_start_i
);

  // Request stays put while the slave has not acked
  stb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_i && !wb_ack_i |=> wb_stb_i && $stable(wb_we_i) &&
                              $stable(wb_adr_i) && $stable(wb_dat_i))
    else $error("Wishbone request dropped or changed before ack");

  ack_needs_stb_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |-> wb_stb_i)
    else $error("Wishbone ack seen without strobe");

  // Strobe ends one cycle after the ack
  stb_drop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_i |=> !wb_stb_i)
    else $error("Wishbone strobe still high after ack");

  // Slave acks in the second cycle of the bus wait
  bus_wait_len_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == ser_wb_pkg::St_BusWait && !wb_ack_i |=> wb_ack_i)
    else $error("Wishbone ack missing in the cycle after the strobe");

  tx_start_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_start_i |-> !tx_busy_i)
    else $error("Transmit start issued while the transmitter was busy");

endmodule

bind ser_wb_ctrl ser_wb_assert u_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .state_i    (state_q),
  .wb_stb_i   (wb_stb_o),
  .wb_we_i    (wb_we_o),
  .wb_adr_i   (wb_adr_o),
  .wb_dat_i   (wb_dat_o),
  .wb_ack_i   (wb_ack_i),
  .tx_busy_i  (tx_busy_i),
  .tx_start_i (tx_start_o)
);

`default_nettype wire

/* src/ser_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ser_wb_top (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rx_i,
  output logic tx_o
);

  logic [ser_wb_pkg::DATA_W-1:0] rx_byte;
  logic                          rx_valid;

  logic                          wb_we;
  logic [ser_wb_pkg::ADR_W-1:0]  wb_adr;
  logic [ser_wb_pkg::DATA_W-1:0] wb_dat_w;
  logic [ser_wb_pkg::DATA_W-1:0] wb_dat_r;
  logic                          wb_stb;
  logic                          wb_ack;

  logic [ser_wb_pkg::DATA_W-1:0] tx_byte;
  logic                          tx_start;
  logic                          tx_busy;

  uart_rx u_rx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_i       (rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  ser_wb_ctrl u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_byte_i  (rx_byte),
    .rx_valid_i (rx_valid),
    .wb_we_o    (wb_we),
    .wb_adr_o   (wb_adr),
    .wb_dat_o   (wb_dat_w),
    .wb_stb_o   (wb_stb),
    .wb_dat_i   (wb_dat_r),
    .wb_ack_i   (wb_ack),
    .tx_busy_i  (tx_busy),
    .tx_byte_o  (tx_byte),
    .tx_start_o (tx_start)
  );

  wb_regfile u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_stb_i (wb_stb),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  uart_tx u_tx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .tx_o       (tx_o),
    .tx_busy_o  (tx_busy)
  );

endmodule

`default_nettype wire

/* src/wb_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_regfile (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wb_we_i,
  input  logic [ser_wb_pkg::ADR_W-1:0]  wb_adr_i,
  input  logic [ser_wb_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                          wb_stb_i,
  output logic [ser_wb_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack_o
);

  logic [ser_wb_pkg::DATA_W-1:0] regs_q [2**ser_wb_pkg::ADR_W];
  logic [ser_wb_pkg::DATA_W-1:0] dat_q;
  logic                          ack_q;
  logic                          access;

  // First strobe cycle of a transfer
  assign access = wb_stb_i && !ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2**ser_wb_pkg::ADR_W; i++) begin
        regs_q[i] <= '0;
      end
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && wb_we_i) begin
        regs_q[wb_adr_i] <= wb_dat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= regs_q[wb_adr_i];
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;

endmodule

`default_nettype wire

/* src/ser_wb_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ser_wb_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Bytes from the receiver
  input  logic [ser_wb_pkg::DATA_W-1:0] rx_byte_i,
  input  logic                          rx_valid_i,

  // Wishbone classic master
  output logic                          wb_we_o,
  output logic [ser_wb_pkg::ADR_W-1:0]  wb_adr_o,
  output logic [ser_wb_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_stb_o,
  input  logic [ser_wb_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i,

  // Response to the transmitter
  input  logic                          tx_busy_i,
  output logic [ser_wb_pkg::DATA_W-1:0] tx_byte_o,
  output logic                          tx_start_o
);

  ser_wb_pkg::ctrl_state_e state_q, state_d;

  logic                          stb_q, stb_d;
  logic                          we_q, we_d;
  logic [ser_wb_pkg::ADR_W-1:0]  adr_q, adr_d;
  logic [ser_wb_pkg::DATA_W-1:0] dat_q, dat_d;
  logic [ser_wb_pkg::DATA_W-1:0] resp_q, resp_d;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ser_wb_pkg::St_Idle;
      stb_q   <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      stb_q   <= stb_d;
      we_q    <= we_d;
    end
  end

  always_ff @(posedge clk_i) begin
    adr_q  <= adr_d;
    dat_q  <= dat_d;
    resp_q <= resp_d;
  end

  always_comb begin
    state_d    = state_q;
    stb_d      = stb_q;
    we_d       = we_q;
    adr_d      = adr_q;
    dat_d      = dat_q;
    resp_d     = resp_q;
    tx_start_o = 1'b0;

    unique case (state_q)
      ser_wb_pkg::St_Idle: begin
        // Command byte, bits 6:4 are don't care
        if (rx_valid_i) begin
          adr_d = rx_byte_i[ser_wb_pkg::ADR_W-1:0];
          we_d  = rx_byte_i[ser_wb_pkg::CMD_WRITE_BIT];
          if (rx_byte_i[ser_wb_pkg::CMD_WRITE_BIT]) begin
            state_d = ser_wb_pkg::St_GetData;
          end else begin
            stb_d   = 1'b1;
            state_d = ser_wb_pkg::St_BusWait;
          end
        end
      end
      ser_wb_pkg::St_GetData: begin
        if (rx_valid_i) begin
          dat_d   = rx_byte_i;
          stb_d   = 1'b1;
          state_d = ser_wb_pkg::St_BusWait;
        end
      end
      ser_wb_pkg::St_BusWait: begin
        if (wb_ack_i) begin
          stb_d   = 1'b0;
          resp_d  = we_q ? ser_wb_pkg::WR_ACK_BYTE : wb_dat_i;
          state_d = ser_wb_pkg::St_Respond;
        end
      end
      ser_wb_pkg::St_Respond: begin
        // Hold the response until the transmitter is free
        if (!tx_busy_i) begin
          tx_start_o = 1'b1;
          state_d    = ser_wb_pkg::St_Idle;
        end
      end
      default: state_d = ser_wb_pkg::St_Idle;
    endcase
  end

  assign wb_stb_o  = stb_q;
  assign wb_we_o   = we_q;
  assign wb_adr_o  = adr_q;
  assign wb_dat_o  = dat_q;
  assign tx_byte_o = resp_q;

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          tx_start_i,
  input  logic [ser_wb_pkg::DATA_W-1:0] tx_byte_i,
  output logic                          tx_o,
  output logic                          tx_busy_o
);

  // Start bit, eight data bits and stop bit
  logic [ser_wb_pkg::DATA_W+1:0]     frame_q;
  logic [ser_wb_pkg::BAUD_CNT_W-1:0] cnt_q;
  logic [3:0]                        bit_cnt_q;
  logic                              busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      frame_q   <= '1;
      cnt_q     <= '0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        frame_q   <= {1'b1, tx_byte_i, 1'b0};
        cnt_q     <= '0;
        bit_cnt_q <= '0;
        busy_q    <= 1'b1;
      end
    end else if (cnt_q == ser_wb_pkg::BAUD_LAST) begin
      cnt_q <= '0;
      // Shift in idle level behind the frame
      frame_q <= {1'b1, frame_q[ser_wb_pkg::DATA_W+1:1]};
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Line is the frame LSB, all ones when idle
  assign tx_o      = frame_q[0];
  assign tx_busy_o = busy_q;

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rx_i,
  output logic [ser_wb_pkg::DATA_W-1:0] rx_byte_o,
  output logic                          rx_valid_o
);

  typedef enum logic [1:0] {
    Rx_Idle,
    Rx_Start,
    Rx_Data,
    Rx_Stop
  } rx_state_e;

  rx_state_e                           state_q;
  logic [1:0]                          sync_q;
  logic                                rx_prev_q;
  logic [ser_wb_pkg::BAUD_CNT_W-1:0]   cnt_q;
  logic [2:0]                          bit_idx_q;
  logic [ser_wb_pkg::DATA_W-1:0]       shift_q;
  logic                                valid_q;
  logic                                rx_s;

  // Synchronized line level
  assign rx_s = sync_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q    <= 2'b11;
      rx_prev_q <= 1'b1;
      state_q   <= Rx_Idle;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      sync_q    <= {sync_q[0], rx_i};
      rx_prev_q <= rx_s;
      valid_q   <= 1'b0;
      unique case (state_q)
        Rx_Idle: begin
          // Falling edge marks a start bit
          if (rx_prev_q && !rx_s) begin
            state_q <= Rx_Start;
            cnt_q   <= '0;
          end
        end
        Rx_Start: begin
          if (cnt_q == ser_wb_pkg::BAUD_HALF) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // Glitch if the line is back high at mid-bit
            state_q   <= rx_s ? Rx_Idle : Rx_Data;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        Rx_Data: begin
          if (cnt_q == ser_wb_pkg::BAUD_LAST) begin
            cnt_q <= '0;
            if (bit_idx_q == 3'd7) begin
              state_q <= Rx_Stop;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        Rx_Stop: begin
          if (cnt_q == ser_wb_pkg::BAUD_LAST) begin
            state_q <= Rx_Idle;
            // Low stop bit drops the frame
            valid_q <= rx_s;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= Rx_Idle;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == Rx_Data && cnt_q == ser_wb_pkg::BAUD_LAST) begin
      shift_q <= {rx_s, shift_q[ser_wb_pkg::DATA_W-1:1]};
    end
  end

  assign rx_byte_o  = shift_q;
  assign rx_valid_o = valid_q;

endmodule

`default_nettype wire

/* common/ser_wb_pkg.sv */
`default_nettype none

package ser_wb_pkg;

  // Byte and bus widths
  localparam int DATA_W = 8;
  localparam int ADR_W  = 4;

  // UART bit timing in clock cycles
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  // Last count of a full bit and of half a bit
  localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [BAUD_CNT_W-1:0] BAUD_HALF = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

  // Command byte layout and write response
  localparam int                CMD_WRITE_BIT = 7;
  localparam logic [DATA_W-1:0] WR_ACK_BYTE   = 8'h01;

  typedef enum logic [2:0] {
    St_Idle,
    St_GetData,
    St_BusWait,
    St_Respond
  } ctrl_state_e;

endpackage

`default_nettype wire
